/* dma_read.f */
+incdir+common
common/dma_read_pkg.sv
hw/spam_config_regs.sv
dma_engine/dma_burst_issuer.sv
dma_engine/dma_burst_collector.sv
hw/dma_word_fifo.sv
hw/dma_read_top.sv
sim/fsab_memory_model.sv
sim/tb_dma_read.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_dma_read
FILELIST = dma_read.f
OBJ_DIR  = obj_dir
SIM      = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the pass line shows up in the output.
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_dma_read.sv */
// DMA read engine testbench
`timescale 1ns/10ps
`default_nettype none

`include "dma_read_macros.svh"

module tb_dma_read;
	import dma_read_pkg::*;

	localparam logic [23:0] WIN = `DMA_SPAM_PREFIX;
	// All test words, with the longest autotrigger tail that stop can leave.
	localparam int TOTAL_WORDS = 32 + 128 + 80 + 8 * 12;
	localparam int CYCLE_LIMIT = TOTAL_WORDS * 16 + 4000;

	logic      clk = 1'b0;
	logic      rst_b = 1'b1;
	spam_wr_t  spam_in = '0;
	logic      request = 1'b0;
	logic      spam_ack;
	fsab_req_t fsab_req;
	logic      fsab_credit;
	fsab_rsp_t fsab_rsp;
	logic [`DMA_DATA_W-1:0] data;
	logic      data_ready;

	logic                   req_enable = 1'b0;
	integer                 seed = 23;
	logic [`DMA_DATA_W-1:0] exp_q [$];
	logic [`DMA_DATA_W-1:0] word_exp;
	logic [31:0]            exp_base = '0;
	int                     exp_words = 0;
	int                     exp_reps = 0;
	int                     post_cnt = 0;
	int                     post_seen = 0;
	logic [31:0]            tail_start = '0;
	int                     tail_words = 0;
	int                     tail_xfers = 0;
	int req_total = 0;
	int credit_total = 0;
	int got_cnt = 0;
	int check_errors = 0;
	int seq_errors = 0;
	int credit_errors = 0;
	int tests = 0;
	int tests_failed = 0;
	int cycle_cnt = 0;

	dma_read_top dut (
		.clk         (clk),
		.rst_b       (rst_b),
		.spam_in     (spam_in),
		.spam_ack    (spam_ack),
		.fsab_req    (fsab_req),
		.fsab_credit (fsab_credit),
		.fsab_rsp    (fsab_rsp),
		.request     (request),
		.data        (data),
		.data_ready  (data_ready)
	);

	fsab_memory_model #(.SEED(23)) mem (
		.clk         (clk),
		.rst_b       (rst_b),
		.fsab_req    (fsab_req),
		.fsab_rsp    (fsab_rsp),
		.fsab_credit (fsab_credit)
	);

	always #10 clk = ~clk;

	// Memory word rule. Beat i of the burst at A holds the word for A + 8 * i.
	function automatic logic [`DMA_DATA_W-1:0] expected_word(input logic [31:0] a);
		return {a ^ 32'hA5A5_5A5A, a};
	endfunction

	function automatic int error_total();
		return check_errors + seq_errors;
	endfunction

	// User port with random gaps while enabled.
	always @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			request <= 1'b0;
		else
			request <= req_enable && (($random(seed) & 3) != 0);
	end

	// Output checks, sampled mid-cycle where everything is stable.
	always @(negedge clk) begin
		if (post_cnt != post_seen) begin
			for (int r = 0; r < exp_reps; r++)
				for (int i = 0; i < exp_words; i++)
					exp_q.push_back(expected_word(exp_base + 32'(8 * i)));
			post_seen = post_cnt;
		end
		if (rst_b) begin
			if (fsab_req.valid) begin
				req_total++;
				assert (int'(fsab_req.beats) == `DMA_BURST_BEATS) else begin
					$display("[FAIL] %0t: request for %0d beats, expected %0d",
						$time, fsab_req.beats, `DMA_BURST_BEATS);
					check_errors++;
				end
			end
			if (fsab_credit)
				credit_total++;
			assert (req_total <= credit_total + `DMA_CREDITS_INIT) else begin
				$display("[FAIL] %0t: %0d requests against %0d returned credits",
					$time, req_total, credit_total);
				credit_errors++;
			end
			if (data_ready) begin
				if ((exp_q.size() == 0) && (tail_words != 0)) begin
					for (int i = 0; i < tail_words; i++)
						exp_q.push_back(expected_word(tail_start + 32'(8 * i)));
					tail_xfers++; // Another autotrigger pass has begun.
				end
				assert (exp_q.size() != 0) else begin
					$display("Error: a word arrived at %0t while no word was expected", $time);
					check_errors++;
				end
				if (exp_q.size() != 0) begin
					word_exp = exp_q.pop_front();
					assert (data == word_exp) else begin
						$display("[FAIL] %0t: word %0d is %h, expected %h",
							$time, got_cnt, data, word_exp);
						check_errors++;
					end
				end
				got_cnt++;
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic spam_write(input logic [23:0] offset, input logic [31:0] value);
		@(posedge clk);
		spam_in <= '{valid: 1'b1, addr: WIN | offset, data: value};
		@(posedge clk);
		spam_in <= '0;
		@(negedge clk);
		assert (spam_ack) else begin
			$display("Error: no spam_ack one cycle after the write to offset %h", offset);
			seq_errors++;
		end
		@(negedge clk);
		assert (!spam_ack) else begin
			$display("Error: spam_ack stayed high after the write to offset %h", offset);
			seq_errors++;
		end
	endtask

	task automatic post_range(input logic [31:0] start, input int words, input int reps);
		exp_base = start;
		exp_words = words;
		exp_reps = reps;
		post_cnt++;
		@(negedge clk);
	endtask

	task automatic finish_test(input string name, input logic passed);
		tests++;
		if (passed) begin
			$display("test %0d %s: passed", tests, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed", tests, name);
		end
	endtask

	initial begin
		int errs;
		int base_req;
		int base_cred;
		int base_got;
		int idle;

		rst_b <= 1'b0;
		repeat (16) @(posedge clk);
		rst_b <= 1'b1;

		errs = error_total();
		@(negedge clk);
		assert (!data_ready && !spam_ack && !fsab_req.valid) else begin
			$display("Error: an output was high straight after reset");
			seq_errors++;
		end
		repeat (30) @(negedge clk);
		assert (req_total == 0) else begin
			$display("Error: a request appeared while the command was stop");
			seq_errors++;
		end
		finish_test("reset and stop", error_total() == errs);

		errs = error_total();
		spam_write(`DMA_REG_START, 32'h0000_4000);
		spam_write(`DMA_REG_LEN, 32'd256);
		spam_write(24'h00000C, 32'h0000_DEAD); // Unknown offset.
		spam_write(`DMA_REG_CMD, 32'd5);       // Not a command.
		repeat (20) @(negedge clk);
		assert (req_total == 0) else begin
			$display("Error: a request appeared although no valid command was written");
			seq_errors++;
		end
		finish_test("configuration writes", error_total() == errs);

		errs = error_total();
		base_req = req_total;
		base_got = got_cnt;
		post_range(32'h0000_4000, 32, 1);
		req_enable <= 1'b1;
		spam_write(`DMA_REG_CMD, 32'(CMD_TRIGGER_ONCE));
		while (got_cnt < base_got + 32)
			@(negedge clk);
		repeat (40) @(negedge clk);
		assert ((req_total == base_req + 4) && (got_cnt == base_got + 32)) else begin
			$display("Error: requests or words went on after the single transfer");
			seq_errors++;
		end
		finish_test("trigger_once 256 bytes", error_total() == errs);

		errs = error_total();
		base_req = req_total;
		base_cred = credit_total;
		base_got = got_cnt;
		req_enable <= 1'b0;
		spam_write(`DMA_REG_START, 32'h0000_8000);
		spam_write(`DMA_REG_LEN, 32'd1024);
		post_range(32'h0000_8000, 128, 1);
		spam_write(`DMA_REG_CMD, 32'(CMD_TRIGGER_ONCE));
		while (credit_total < base_cred + 8) // The FIFO holds eight bursts.
			@(negedge clk);
		repeat (40) @(negedge clk);
		assert ((req_total == base_req + 8) && (got_cnt == base_got)) else begin
			$display("Error: issuing did not stop with the FIFO full");
			seq_errors++;
		end
		req_enable <= 1'b1;
		while (got_cnt < base_got + 128)
			@(negedge clk);
		repeat (40) @(negedge clk);
		assert ((exp_q.size() == 0) && (req_total == base_req + 16)) else begin
			$display("Error: the held transfer did not finish with every word once");
			seq_errors++;
		end
		finish_test("FIFO back-pressure", error_total() == errs);

		errs = error_total();
		base_req = req_total;
		base_cred = credit_total;
		base_got = got_cnt;
		req_enable <= 1'b0;
		spam_write(`DMA_REG_START, 32'h0000_C000);
		spam_write(`DMA_REG_LEN, 32'd128);
		// Four passes fill the FIFO and the fifth is latched before the new length.
		post_range(32'h0000_C000, 16, 5);
		spam_write(`DMA_REG_CMD, 32'(CMD_AUTOTRIGGER));
		while (credit_total < base_cred + 8)
			@(negedge clk);
		repeat (40) @(negedge clk);
		assert (req_total == base_req + 8) else begin
			$display("Error: autotrigger did not hold with the FIFO full");
			seq_errors++;
		end
		tail_start = 32'h0000_C000;
		tail_words = 8;
		spam_write(`DMA_REG_LEN, 32'd64);
		req_enable <= 1'b1;
		while (got_cnt < base_got + 96)
			@(negedge clk);
		spam_write(`DMA_REG_CMD, 32'(CMD_STOP));
		idle = 0;
		while (idle < 100) begin
			@(negedge clk);
			if (data_ready || fsab_req.valid)
				idle = 0;
			else
				idle++;
		end
		assert ((exp_q.size() == 0) && (tail_xfers <= 12) &&
			(req_total == credit_total)) else begin
			$display("Error: autotrigger did not end on whole transfers after stop");
			seq_errors++;
		end
		finish_test("autotrigger with new length", error_total() == errs);

		finish_test("FSAB requests within credits", credit_errors == 0);

		$display("tests %0d, passed %0d, failed %0d, errors %0d", tests,
			tests - tests_failed, tests_failed, error_total() + credit_errors);
		if ((tests_failed == 0) && (error_total() + credit_errors == 0))
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/fsab_memory_model.sv */
// FSAB read memory model
`timescale 1ns/10ps
`default_nettype none

`include "dma_read_macros.svh"

module fsab_memory_model #(
	parameter int SEED = 23
) (
	input  logic                    clk,
	input  logic                    rst_b,
	input  dma_read_pkg::fsab_req_t fsab_req,
	output dma_read_pkg::fsab_rsp_t fsab_rsp,
	output logic                    fsab_credit
);
	import dma_read_pkg::*;

	logic [`DMA_ADDR_W-1:0] pending [$]; // Burst addresses in request order.
	logic [`DMA_ADDR_W-1:0] base;
	logic                   busy;
	logic                   credit_due;
	int                     beat;
	int                     gap;
	integer                 seed;

	// Each beat carries its own byte address, with a scrambled copy on top.
	function automatic logic [`DMA_DATA_W-1:0] beat_word(input logic [`DMA_ADDR_W-1:0] a);
		return {a ^ 32'hA5A5_5A5A, a};
	endfunction

	always @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			pending.delete();
			busy = 1'b0;
			credit_due = 1'b0;
			beat = 0;
			gap = 0;
			seed = SEED;
			fsab_rsp <= '0;
			fsab_credit <= 1'b0;
		end else begin
			fsab_rsp <= '0;
			fsab_credit <= credit_due; // The slot frees one cycle after the last beat.
			credit_due = 1'b0;
			if (fsab_req.valid)
				pending.push_back(fsab_req.addr);
			if (!busy && (pending.size() != 0)) begin
				base = pending.pop_front();
				beat = 0;
				gap = $unsigned($random(seed)) % 4;
				busy = 1'b1;
			end else if (busy) begin
				if (gap != 0) begin
					gap--;
				end else begin
					fsab_rsp <= '{valid: 1'b1, data: beat_word(base + 32'(8 * beat))};
					beat++;
					gap = $unsigned($random(seed)) % 3; // Idle cycles inside the burst.
					if (beat == `DMA_BURST_BEATS) begin
						busy = 1'b0;
						credit_due = 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hw/dma_read_top.sv */
// DMA read engine top level
// Registers, issuer, collector and FIFO in a chain.
`timescale 1ns/10ps
`default_nettype none

`include "dma_read_macros.svh"

module dma_read_top (
	input  logic                    clk,
	input  logic                    rst_b,
	input  dma_read_pkg::spam_wr_t  spam_in,
	output logic                    spam_ack,
	output dma_read_pkg::fsab_req_t fsab_req,
	input  logic                    fsab_credit,
	input  dma_read_pkg::fsab_rsp_t fsab_rsp,
	input  logic                    request,
	output logic [`DMA_DATA_W-1:0]  data,
	output logic                    data_ready
);
	import dma_read_pkg::*;

	dma_cfg_t                         cfg;
	logic                             cmd_taken;
	logic [$clog2(`DMA_FIFO_DEPTH):0] fifo_room;
	logic                             burst_done;
	logic                             fifo_push;
	logic [`DMA_DATA_W-1:0]           fifo_wdata;

	spam_config_regs u_regs (
		.clk       (clk),
		.rst_b     (rst_b),
		.spam_in   (spam_in),
		.cmd_taken (cmd_taken),
		.cfg       (cfg),
		.spam_ack  (spam_ack)
	);

	// Room and finished bursts come back upstream as the issuer's second credit.
	dma_burst_issuer u_issuer (
		.clk         (clk),
		.rst_b       (rst_b),
		.cfg         (cfg),
		.fifo_room   (fifo_room),
		.burst_done  (burst_done),
		.fsab_credit (fsab_credit),
		.fsab_req    (fsab_req),
		.cmd_taken   (cmd_taken)
	);

	dma_burst_collector u_collector (
		.clk        (clk),
		.rst_b      (rst_b),
		.fsab_rsp   (fsab_rsp),
		.fifo_push  (fifo_push),
		.fifo_wdata (fifo_wdata),
		.burst_done (burst_done)
	);

	dma_word_fifo u_fifo (
		.clk        (clk),
		.rst_b      (rst_b),
		.fifo_push  (fifo_push),
		.fifo_wdata (fifo_wdata),
		.request    (request),
		.fifo_room  (fifo_room),
		.data       (data),
		.data_ready (data_ready)
	);

endmodule

`default_nettype wire

/* hw/dma_word_fifo.sv */
// Word FIFO and user read port
`timescale 1ns/10ps
`default_nettype none

`include "dma_read_macros.svh"

module dma_word_fifo (
	input  logic                             clk,
	input  logic                             rst_b,
	input  logic                             fifo_push,
	input  logic [`DMA_DATA_W-1:0]           fifo_wdata,
	input  logic                             request,
	output logic [$clog2(`DMA_FIFO_DEPTH):0] fifo_room,
	output logic [`DMA_DATA_W-1:0]           data,
	output logic                             data_ready
);

	localparam int PTR_W = $clog2(`DMA_FIFO_DEPTH);
	localparam logic [PTR_W:0] DEPTH = (PTR_W + 1)'(`DMA_FIFO_DEPTH);

	logic [`DMA_DATA_W-1:0] mem [`DMA_FIFO_DEPTH];
	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;
	logic [PTR_W:0]         count; // One bit wider so a full queue is told from an empty one.
	logic                   pop;

	// A request against an empty queue is simply not served.
	assign pop = request && (count != '0);

	// The issuer reserves room before it asks, so pushes never meet a full queue.
	assign fifo_room = DEPTH - count;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			data_ready <= 1'b0;
		end else begin
			data_ready <= pop;
			if (fifo_push)
				wr_ptr <= wr_ptr + 1'b1; // Pointers wrap with the power-of-two depth.
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({fifo_push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fifo_push)
			mem[wr_ptr] <= fifo_wdata;
	end

	// The oldest word goes out with data_ready in the next cycle.
	always_ff @(posedge clk) begin
		if (pop)
			data <= mem[rd_ptr];
	end

endmodule

`default_nettype wire

/* dma_engine/dma_burst_collector.sv */
// Burst collector
// Response beats to FIFO pushes.
`timescale 1ns/10ps
`default_nettype none

`include "dma_read_macros.svh"

module dma_burst_collector (
	input  logic                    clk,
	input  logic                    rst_b,
	input  dma_read_pkg::fsab_rsp_t fsab_rsp,
	output logic                    fifo_push,
	output logic [`DMA_DATA_W-1:0]  fifo_wdata,
	output logic                    burst_done
);
	import dma_read_pkg::*;

	localparam int BEAT_W = $clog2(`DMA_BURST_BEATS);
	localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`DMA_BURST_BEATS - 1);

	logic [BEAT_W-1:0] beat_cnt; // Position of the next beat inside its burst.
	logic              last_beat;

	// Bursts come back in request order, so a plain beat count finds their ends.
	assign last_beat = fsab_rsp.valid && (beat_cnt == LAST_BEAT);

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			beat_cnt <= '0;
		end else if (fsab_rsp.valid) begin
			if (last_beat)
				beat_cnt <= '0;
			else
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

	// Push strobe and burst end leave together, one cycle after the beat.
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			fifo_push <= 1'b0;
			burst_done <= 1'b0;
		end else begin
			fifo_push <= fsab_rsp.valid;
			burst_done <= last_beat;
		end
	end

	// Beat data toward the FIFO, valid while fifo_push is high.
	always_ff @(posedge clk) begin
		if (fsab_rsp.valid)
			fifo_wdata <= fsab_rsp.data;
	end

endmodule

`default_nettype wire

/* dma_engine/dma_burst_issuer.sv */
// Burst issuer
// Trigger FSM with bus and FIFO credit tracking.
`timescale 1ns/10ps
`default_nettype none

`include "dma_read_macros.svh"

module dma_burst_issuer (
	input  logic                             clk,
	input  logic                             rst_b,
	input  dma_read_pkg::dma_cfg_t           cfg,
	input  logic [$clog2(`DMA_FIFO_DEPTH):0] fifo_room,
	input  logic                             burst_done,
	input  logic                             fsab_credit,
	output dma_read_pkg::fsab_req_t          fsab_req,
	output logic                             cmd_taken
);
	import dma_read_pkg::*;

	// Enough to count every burst the FIFO could ever hold.
	localparam int INFL_W = $clog2(`DMA_FIFO_DEPTH / `DMA_BURST_BEATS) + 1;

	issuer_state_e            state;
	logic [`DMA_ADDR_W-1:0]   addr;
	logic [`DMA_ADDR_W-1:0]   end_addr;
	logic [`DMA_CREDIT_W-1:0] credits;
	logic [INFL_W-1:0]        inflight;
	logic                     more;
	logic                     room_ok;
	logic                     issue;

	assign cmd_taken = (state == ISS_IDLE) &&
		((cfg.cmd == CMD_TRIGGER_ONCE) || (cfg.cmd == CMD_AUTOTRIGGER));
	assign more = addr < end_addr; // Some of the range is still unrequested.

	// Room must cover every burst already on its way plus this one.
	assign room_ok = int'(fifo_room) >= `DMA_BURST_BEATS * (int'(inflight) + 1);
	assign issue = (state == ISS_ISSUE) && more && (credits != '0) && room_ok;

	always_comb begin
		fsab_req.valid = issue;
		fsab_req.addr = addr;
		fsab_req.beats = `DMA_BEATS_W'(`DMA_BURST_BEATS);
	end

	// Bus request slots. A slot is used by each request and freed by each credit.
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			credits <= `DMA_CREDIT_W'(`DMA_CREDITS_INIT);
		else
			credits <= credits + `DMA_CREDIT_W'(fsab_credit) - `DMA_CREDIT_W'(issue);
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			inflight <= '0;
		end else begin
			case ({issue, burst_done})
				2'b10: inflight <= inflight + 1'b1;
				2'b01: inflight <= inflight - 1'b1;
				default: inflight <= inflight; // Both or neither.
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			state <= ISS_IDLE;
			addr <= '0;
			end_addr <= '0;
		end else begin
			case (state)
				ISS_IDLE: begin
					// Autotrigger stays set, so this restarts after each drain.
					if (cmd_taken) begin
						addr <= cfg.start;
						end_addr <= cfg.start + `DMA_ADDR_W'(cfg.len);
						state <= ISS_ISSUE;
					end
				end
				ISS_ISSUE: begin
					if (issue)
						addr <= addr + `DMA_ADDR_W'(`DMA_BURST_BYTES);
					else if (!more)
						state <= ISS_DRAIN;
				end
				ISS_DRAIN: begin
					if (inflight == '0) // All bursts have reached the FIFO.
						state <= ISS_IDLE;
				end
				default: state <= ISS_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/spam_config_regs.sv */
// SPAM configuration registers
`timescale 1ns/10ps
`default_nettype none

`include "dma_read_macros.svh"

module spam_config_regs (
	input  logic                   clk,
	input  logic                   rst_b,
	input  dma_read_pkg::spam_wr_t spam_in,
	input  logic                   cmd_taken,
	output dma_read_pkg::dma_cfg_t cfg,
	output logic                   spam_ack
);
	import dma_read_pkg::*;

	logic                        hit;
	logic [`DMA_SPAM_ADDR_W-1:0] offset;
	logic                        cmd_ok;

	assign hit = spam_in.valid &&
		((spam_in.addr & `DMA_SPAM_MASK) == `DMA_SPAM_PREFIX); // Window match.
	assign offset = spam_in.addr & ~`DMA_SPAM_MASK;

	// Only the defined command codes reach the register.
	always_comb begin
		case (spam_in.data)
			`DMA_SPAM_DATA_W'(CMD_STOP),
			`DMA_SPAM_DATA_W'(CMD_TRIGGER_ONCE),
			`DMA_SPAM_DATA_W'(CMD_AUTOTRIGGER): cmd_ok = 1'b1;
			default: cmd_ok = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			cfg.start <= '0;
			cfg.len <= '0;
			cfg.cmd <= CMD_STOP;
			spam_ack <= 1'b0;
		end else begin
			spam_ack <= hit; // Every write in the window is acknowledged.

			// A single-shot command is spent once the issuer takes it.
			if (cmd_taken && (cfg.cmd == CMD_TRIGGER_ONCE))
				cfg.cmd <= CMD_STOP;

			// A host write on the same edge is newer and wins.
			if (hit) begin
				case (offset)
					`DMA_REG_START: cfg.start <= spam_in.data[`DMA_ADDR_W-1:0];
					`DMA_REG_LEN: cfg.len <= spam_in.data[`DMA_LEN_W-1:0];
					`DMA_REG_CMD: begin
						if (cmd_ok)
							cfg.cmd <= dma_cmd_e'(spam_in.data[1:0]);
					end
					default: begin
						// Unknown offsets leave the registers alone.
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* common/dma_read_pkg.sv */
// DMA read engine types
`default_nettype none

`include "dma_read_macros.svh"

package dma_read_pkg;

	// Command register codes. The value 3 is not a command.
	typedef enum logic [1:0] {
		CMD_STOP         = 2'd0,
		CMD_TRIGGER_ONCE = 2'd1,
		CMD_AUTOTRIGGER  = 2'd2
	} dma_cmd_e;

	typedef enum logic [1:0] {
		ISS_IDLE  = 2'd0,
		ISS_ISSUE = 2'd1,
		ISS_DRAIN = 2'd2
	} issuer_state_e;

	// Read request toward memory, one per burst.
	typedef struct packed {
		logic                    valid;
		logic [`DMA_ADDR_W-1:0]  addr;
		logic [`DMA_BEATS_W-1:0] beats;
	} fsab_req_t;

	// One response beat.
	typedef struct packed {
		logic                   valid;
		logic [`DMA_DATA_W-1:0] data;
	} fsab_rsp_t;

	typedef struct packed {
		logic                        valid;
		logic [`DMA_SPAM_ADDR_W-1:0] addr;
		logic [`DMA_SPAM_DATA_W-1:0] data;
	} spam_wr_t;

	// Transfer setup handed from the register stage to the issuer.
	typedef struct packed {
		logic [`DMA_ADDR_W-1:0] start;
		logic [`DMA_LEN_W-1:0]  len;
		dma_cmd_e               cmd;
	} dma_cfg_t;

endpackage

`default_nettype wire

/* common/dma_read_macros.svh */
// DMA read engine parameters
// Widths, credits, burst and register map.
`ifndef DMA_READ_MACROS_SVH
`define DMA_READ_MACROS_SVH

// FSAB side.
`define DMA_ADDR_W        32
`define DMA_DATA_W        64
`define DMA_BEATS_W       7
`define DMA_BURST_BEATS   8
`define DMA_BURST_BYTES   64

// Transfer length in bytes.
`define DMA_LEN_W         32

// Request slots granted by the bus after reset.
`define DMA_CREDITS_INIT  4
`define DMA_CREDIT_W      3

// The word queue depth must stay a power of two.
`define DMA_FIFO_DEPTH    64

// SPAM configuration bus and the window this block answers.
`define DMA_SPAM_ADDR_W   24
`define DMA_SPAM_DATA_W   32
`define DMA_SPAM_PREFIX   24'h001000
`define DMA_SPAM_MASK     24'hFFFFF0

// Register offsets inside the window.
`define DMA_REG_START     24'h000000
`define DMA_REG_LEN       24'h000004
`define DMA_REG_CMD       24'h000008

`endif
